/* logic/seg7_pkg.sv */
`default_nettype none

package seg7_pkg;

  // scan geometry
  parameter int NUM_DIGITS = 8;
  parameter int SEG_W = 8;
  parameter int DIGIT_IDX_W = 3;

  // register map, word offsets
  parameter int REG_IDX_W = 4;
  parameter int CTRL_REG_IDX = 8;

  // AHB-lite widths
  parameter int ADDR_W = 16;
  parameter int DATA_W = 32;

  // pattern byte followed by one-hot select byte
  parameter int FRAME_W = 16;

  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  // segments a..g in bits 0..6, decimal point in bit 7
  typedef logic [SEG_W-1:0] seg_pattern_t;

  typedef logic [REG_IDX_W-1:0] reg_idx_t;

endpackage

`default_nettype wire

/* logic/seg7_reg_if.sv */
`default_nettype none

interface seg7_reg_if;

  // write strobe, one cycle per access
  logic                          wr_en;
  seg7_pkg::reg_idx_t            wr_idx;
  logic [seg7_pkg::DATA_W-1:0]   wr_data;

  // read path, data follows the index without a clock
  seg7_pkg::reg_idx_t            rd_idx;
  logic [seg7_pkg::DATA_W-1:0]   rd_data;

  modport master (
    output wr_en, wr_idx, wr_data, rd_idx,
    input  rd_data
  );

  modport target (
    input  wr_en, wr_idx, wr_data, rd_idx,
    output rd_data
  );

endinterface

`default_nettype wire

/* logic/seg7_bus_slave.sv */
`default_nettype none

module seg7_bus_slave (
  input  wire                            CLK_CM3,
  input  wire                            rst_n,
  input  wire                            hsel,
  input  wire [seg7_pkg::ADDR_W-1:0]     haddr,
  input  wire seg7_pkg::htrans_t         htrans,
  input  wire                            hwrite,
  input  wire [seg7_pkg::DATA_W-1:0]     hwdata,
  input  wire                            hready,
  output logic                           hreadyout,
  output logic [seg7_pkg::DATA_W-1:0]    hrdata,
  output logic                           hresp,
  seg7_reg_if.master                     regs
);

  logic               addr_accept;
  logic               dph_valid;
  logic               dph_write;
  seg7_pkg::reg_idx_t dph_idx;

  // NONSEQ and SEQ both have the high bit of htrans set
  assign addr_accept = hsel & hready & htrans[1];

  // capture the address phase for use in the next cycle
  always_ff @(posedge CLK_CM3 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      dph_valid <= 1'b0;
      dph_write <= 1'b0;
      dph_idx   <= '0;
    end
    else if (hready)
    begin
      dph_valid <= addr_accept;
      dph_write <= hwrite;
      dph_idx   <= haddr[seg7_pkg::REG_IDX_W+1:2];
    end
  end

  // data phase of a write, hwdata is valid now
  assign regs.wr_en   = dph_valid & dph_write;
  assign regs.wr_idx  = dph_idx;
  assign regs.wr_data = hwdata;

  // data phase of a read
  // a write one transfer earlier has already landed at the last edge
  assign regs.rd_idx = dph_idx;

  always_comb
  begin
    hrdata = '0;
    if (dph_valid && !dph_write)
    begin
      hrdata = regs.rd_data;
    end
  end

  // zero wait states, never an error
  assign hreadyout = 1'b1;
  assign hresp     = 1'b0;

endmodule

`default_nettype wire

/* logic/seg7_digit_regs.sv */
`default_nettype none

module seg7_digit_regs (
  input  wire                                 CLK_CM3,
  input  wire                                 rst_n,
  seg7_reg_if.target                          regs,
  input  wire [seg7_pkg::DIGIT_IDX_W-1:0]     scan_idx,
  output seg7_pkg::seg_pattern_t              scan_pattern,
  output logic                                scan_enable
);

  seg7_pkg::seg_pattern_t patterns [seg7_pkg::NUM_DIGITS];
  logic                   enable;

  always_ff @(posedge CLK_CM3 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < seg7_pkg::NUM_DIGITS; i++)
      begin
        patterns[i] <= '0;
      end
      enable <= 1'b0;
    end
    else if (regs.wr_en)
    begin
      if (regs.wr_idx < seg7_pkg::CTRL_REG_IDX)
      begin
        // only the low byte is kept
        patterns[regs.wr_idx[seg7_pkg::DIGIT_IDX_W-1:0]] <= regs.wr_data[seg7_pkg::SEG_W-1:0];
      end
      else if (regs.wr_idx == seg7_pkg::CTRL_REG_IDX)
      begin
        enable <= regs.wr_data[0];
      end
      // offsets above control are dropped
    end
  end

  // bus read decode, unmapped offsets return zero
  always_comb
  begin
    regs.rd_data = '0;
    if (regs.rd_idx < seg7_pkg::CTRL_REG_IDX)
    begin
      regs.rd_data = seg7_pkg::DATA_W'(patterns[regs.rd_idx[seg7_pkg::DIGIT_IDX_W-1:0]]);
    end
    else if (regs.rd_idx == seg7_pkg::CTRL_REG_IDX)
    begin
      regs.rd_data = seg7_pkg::DATA_W'(enable);
    end
  end

  // scan port runs beside the bus port
  assign scan_pattern = patterns[scan_idx];
  assign scan_enable  = enable;

endmodule

`default_nettype wire

/* logic/seg7_shift_out.sv */
`default_nettype none

module seg7_shift_out #(
  parameter int CLK_DIV = 2
) (
  input  wire                                 CLK_CM3,
  input  wire                                 rst_n,
  input  wire                                 scan_enable,
  input  wire seg7_pkg::seg_pattern_t         scan_pattern,
  output logic [seg7_pkg::DIGIT_IDX_W-1:0]    scan_idx,
  output logic                                sh_clk,
  output logic                                ld_clk,
  output logic                                hc_dat
);

  localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
  localparam int BIT_W = $clog2(seg7_pkg::FRAME_W);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_LOAD,
    ST_SHIFT_LO,
    ST_SHIFT_HI,
    ST_LATCH,
    ST_NEXT
  } phase_t;

  phase_t                               state;
  logic [DIV_W-1:0]                     div_cnt;
  logic                                 half_end;
  logic                                 timed;
  logic [BIT_W-1:0]                     bit_cnt;
  logic [seg7_pkg::NUM_DIGITS-1:0]      digit_sel;
  logic [seg7_pkg::FRAME_W-1:0]         frame;

  // one-hot select byte, bit i for digit i
  assign digit_sel = seg7_pkg::NUM_DIGITS'(1) << scan_idx;

  // states whose length is a half-period
  assign timed    = (state == ST_SHIFT_LO) || (state == ST_SHIFT_HI) || (state == ST_LATCH);
  assign half_end = (div_cnt == DIV_W'(CLK_DIV - 1));

  always_ff @(posedge CLK_CM3 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= ST_IDLE;
      div_cnt  <= '0;
      bit_cnt  <= '0;
      scan_idx <= '0;
      sh_clk   <= 1'b0;
      ld_clk   <= 1'b0;
      hc_dat   <= 1'b0;
    end
    else if (!scan_enable)
    begin
      // abandon the frame, back to digit 0 with quiet pins
      state    <= ST_IDLE;
      div_cnt  <= '0;
      bit_cnt  <= '0;
      scan_idx <= '0;
      sh_clk   <= 1'b0;
      ld_clk   <= 1'b0;
      hc_dat   <= 1'b0;
    end
    else
    begin
      if (timed && !half_end)
      begin
        div_cnt <= div_cnt + 1'b1;
      end
      else
      begin
        div_cnt <= '0;
      end

      case (state)
        ST_IDLE:
        begin
          state <= ST_LOAD;
        end
        ST_LOAD:
        begin
          // msb of the new frame goes out first
          hc_dat  <= scan_pattern[seg7_pkg::SEG_W-1];
          bit_cnt <= '0;
          state   <= ST_SHIFT_LO;
        end
        ST_SHIFT_LO:
        begin
          if (half_end)
          begin
            sh_clk <= 1'b1;
            state  <= ST_SHIFT_HI;
          end
        end
        ST_SHIFT_HI:
        begin
          if (half_end)
          begin
            sh_clk <= 1'b0;
            if (bit_cnt == BIT_W'(seg7_pkg::FRAME_W - 1))
            begin
              ld_clk <= 1'b1;
              state  <= ST_LATCH;
            end
            else
            begin
              hc_dat  <= frame[seg7_pkg::FRAME_W-2];
              bit_cnt <= bit_cnt + 1'b1;
              state   <= ST_SHIFT_LO;
            end
          end
        end
        ST_LATCH:
        begin
          if (half_end)
          begin
            ld_clk <= 1'b0;
            state  <= ST_NEXT;
          end
        end
        ST_NEXT:
        begin
          if (scan_idx == seg7_pkg::DIGIT_IDX_W'(seg7_pkg::NUM_DIGITS - 1))
          begin
            scan_idx <= '0;
          end
          else
          begin
            scan_idx <= scan_idx + 1'b1;
          end
          state <= ST_LOAD;
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // frame shift register, pattern sampled once per frame
  always_ff @(posedge CLK_CM3 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      frame <= '0;
    end
    else if (state == ST_LOAD)
    begin
      frame <= {scan_pattern, digit_sel};
    end
    else if (state == ST_SHIFT_HI && half_end)
    begin
      frame <= frame << 1;
    end
  end

endmodule

`default_nettype wire

/* logic/seg7_ahb_top.sv */
`default_nettype none

module seg7_ahb_top #(
  parameter int CLK_DIV = 2
) (
  input  wire                            CLK_CM3,
  input  wire                            rst_n,
  // AHB-lite target
  input  wire                            hsel,
  input  wire [seg7_pkg::ADDR_W-1:0]     haddr,
  input  wire seg7_pkg::htrans_t         htrans,
  input  wire [2:0]                      hsize,
  input  wire                            hwrite,
  input  wire [seg7_pkg::DATA_W-1:0]     hwdata,
  input  wire                            hready,
  output logic                           hreadyout,
  output logic [seg7_pkg::DATA_W-1:0]    hrdata,
  output logic                           hresp,
  // 74HC595 chain
  output logic                           sh_clk,
  output logic                           ld_clk,
  output logic                           hc_dat
);

  // hsize not decoded, word accesses only

  seg7_reg_if reg_bus ();

  logic [seg7_pkg::DIGIT_IDX_W-1:0] scan_idx;
  seg7_pkg::seg_pattern_t           scan_pattern;
  logic                             scan_enable;

  seg7_bus_slave u_bus_slave (
    .CLK_CM3   (CLK_CM3),
    .rst_n     (rst_n),
    .hsel      (hsel),
    .haddr     (haddr),
    .htrans    (htrans),
    .hwrite    (hwrite),
    .hwdata    (hwdata),
    .hready    (hready),
    .hreadyout (hreadyout),
    .hrdata    (hrdata),
    .hresp     (hresp),
    .regs      (reg_bus.master)
  );

  seg7_digit_regs u_digit_regs (
    .CLK_CM3      (CLK_CM3),
    .rst_n        (rst_n),
    .regs         (reg_bus.target),
    .scan_idx     (scan_idx),
    .scan_pattern (scan_pattern),
    .scan_enable  (scan_enable)
  );

  seg7_shift_out #(
    .CLK_DIV (CLK_DIV)
  ) u_shift_out (
    .CLK_CM3      (CLK_CM3),
    .rst_n        (rst_n),
    .scan_enable  (scan_enable),
    .scan_pattern (scan_pattern),
    .scan_idx     (scan_idx),
    .sh_clk       (sh_clk),
    .ld_clk       (ld_clk),
    .hc_dat       (hc_dat)
  );

endmodule

`default_nettype wire

/* test/seg7_assertions.sv */
`default_nettype none

module seg7_assertions (
  input wire CLK_CM3,
  input wire rst_n,
  input wire hreadyout,
  input wire hresp,
  input wire sh_clk,
  input wire ld_clk,
  input wire hc_dat
);

  // zero wait states, no error responses
  a_hreadyout_high: assert property (@(posedge CLK_CM3) disable iff (!rst_n) hreadyout)
    else $error("hreadyout went low");

  a_hresp_okay: assert property (@(posedge CLK_CM3) disable iff (!rst_n) !hresp)
    else $error("hresp went high");

  // shift and latch clocks never overlap
  a_clocks_apart: assert property (@(posedge CLK_CM3) disable iff (!rst_n) !(sh_clk && ld_clk))
    else $error("sh_clk and ld_clk high together");

  // serial data holds while the 595 samples it
  a_data_stable: assert property (@(posedge CLK_CM3) disable iff (!rst_n)
    sh_clk |-> $stable(hc_dat))
    else $error("hc_dat changed while sh_clk was high");

endmodule

bind seg7_ahb_top seg7_assertions u_assertions (
  .CLK_CM3   (CLK_CM3),
  .rst_n     (rst_n),
  .hreadyout (hreadyout),
  .hresp     (hresp),
  .sh_clk    (sh_clk),
  .ld_clk    (ld_clk),
  .hc_dat    (hc_dat)
);

`default_nettype wire

/* test/seg7_tb.sv */
`default_nettype none

module seg7_tb;

  localparam int CLK_DIV      = 2;
  localparam int WAIT_LIMIT   = 200;
  localparam int QUIET_CYCLES = 200;
  localparam int CTRL         = seg7_pkg::CTRL_REG_IDX;

  logic                        CLK_CM3;
  logic                        rst_n;
  logic                        hsel;
  logic [seg7_pkg::ADDR_W-1:0] haddr;
  seg7_pkg::htrans_t           htrans;
  logic [2:0]                  hsize;
  logic                        hwrite;
  logic [seg7_pkg::DATA_W-1:0] hwdata;
  logic                        hready;
  logic                        hreadyout;
  logic [seg7_pkg::DATA_W-1:0] hrdata;
  logic                        hresp;
  logic                        sh_clk;
  logic                        ld_clk;
  logic                        hc_dat;

  logic [31:0] rng_state;
  // what each digit register should hold
  logic [7:0]  exp_pat [8];

  seg7_ahb_top #(
    .CLK_DIV (CLK_DIV)
  ) DUT (
    .CLK_CM3   (CLK_CM3),
    .rst_n     (rst_n),
    .hsel      (hsel),
    .haddr     (haddr),
    .htrans    (htrans),
    .hsize     (hsize),
    .hwrite    (hwrite),
    .hwdata    (hwdata),
    .hready    (hready),
    .hreadyout (hreadyout),
    .hrdata    (hrdata),
    .hresp     (hresp),
    .sh_clk    (sh_clk),
    .ld_clk    (ld_clk),
    .hc_dat    (hc_dat)
  );

  initial
  begin
    CLK_CM3 = 1'b0;
    forever
    begin
      #10 CLK_CM3 = ~CLK_CM3;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic end_with_failure();
    $display("TEST FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
      end_with_failure();
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge CLK_CM3);
    #1;
  endtask

  // address phase now, data phase values go out after the next edge
  task automatic bus_transfer(input logic sel, input seg7_pkg::htrans_t trans,
                              input logic write, input int idx, input logic [31:0] wdata);
    hsel   = sel;
    htrans = trans;
    hwrite = write;
    haddr  = seg7_pkg::ADDR_W'(idx << 2);
    @(posedge CLK_CM3);
    #1;
    hwdata = wdata;
    hsel   = 1'b0;
    htrans = seg7_pkg::IDLE;
    hwrite = 1'b0;
  endtask

  task automatic ahb_write(input int idx, input logic [31:0] data);
    bus_transfer(1'b1, seg7_pkg::NONSEQ, 1'b1, idx, data);
  endtask

  // hwdata is left alone, a pending write may still own it
  task automatic ahb_read(input int idx, output logic [31:0] data);
    bus_transfer(1'b1, seg7_pkg::NONSEQ, 1'b0, idx, hwdata);
    @(negedge CLK_CM3);
    data = hrdata;
    @(posedge CLK_CM3);
    #1;
  endtask

  task automatic read_expect(input int idx, input logic [31:0] expected);
    logic [31:0] value;
    ahb_read(idx, value);
    check($sformatf("hrdata[%0d]", idx), value, expected);
  endtask

  // pins sampled at the falling clock edge
  task automatic wait_sh_rise();
    logic seen_low;
    int   cycles;
    seen_low = 1'b0;
    cycles   = 0;
    @(negedge CLK_CM3);
    while (!(seen_low && sh_clk))
    begin
      if (!sh_clk)
      begin
        seen_low = 1'b1;
      end
      if (cycles == WAIT_LIMIT)
      begin
        $display("sh_clk did not rise within %0d cycles", WAIT_LIMIT);
        end_with_failure();
      end
      cycles++;
      @(negedge CLK_CM3);
    end
  endtask

  // no further shift pulse may come between the last bit and the latch
  task automatic wait_ld_high();
    logic sh_fell;
    int   cycles;
    sh_fell = 1'b0;
    cycles  = 0;
    @(negedge CLK_CM3);
    while (!ld_clk)
    begin
      if (!sh_clk)
      begin
        sh_fell = 1'b1;
      end
      else if (sh_fell)
      begin
        $display("sh_clk pulsed again after %0d bits instead of ld_clk", seg7_pkg::FRAME_W);
        end_with_failure();
      end
      if (cycles == WAIT_LIMIT)
      begin
        $display("ld_clk did not pulse within %0d cycles", WAIT_LIMIT);
        end_with_failure();
      end
      cycles++;
      @(negedge CLK_CM3);
    end
  endtask

  // msb first, so the first bit ends up on top
  task automatic capture_frame(output logic [15:0] bits);
    bits = '0;
    for (int i = 0; i < seg7_pkg::FRAME_W; i++)
    begin
      wait_sh_rise();
      bits = {bits[14:0], hc_dat};
    end
    wait_ld_high();
  endtask

  task automatic reset_dut();
    rst_n  = 1'b0;
    hsel   = 1'b0;
    haddr  = '0;
    htrans = seg7_pkg::IDLE;
    hsize  = 3'b010;
    hwrite = 1'b0;
    hwdata = '0;
    hready = 1'b1;
    repeat (2) @(posedge CLK_CM3);
    #1;
    rst_n = 1'b1;
    wait_cycles(1);
  endtask

  task automatic reset_values();
    check("sh_clk", 32'(sh_clk), 32'h0);
    check("ld_clk", 32'(ld_clk), 32'h0);
    check("hc_dat", 32'(hc_dat), 32'h0);
    for (int i = 0; i <= CTRL; i++)
    begin
      read_expect(i, 32'h0);
    end
  endtask

  task automatic digit_readback();
    logic [31:0] data;
    // back-to-back writes, each data phase overlaps the next address
    for (int d = 0; d < 8; d++)
    begin
      rng_state = xorshift32(rng_state);
      data = rng_state;
      exp_pat[3'(d)] = data[7:0];
      ahb_write(d, data);
    end
    for (int d = 0; d < 8; d++)
    begin
      read_expect(d, 32'(exp_pat[3'(d)]));
    end
    // read straight after a write to the same register
    for (int d = 2; d < 8; d += 3)
    begin
      rng_state = xorshift32(rng_state);
      data = rng_state;
      exp_pat[3'(d)] = data[7:0];
      ahb_write(d, data);
      read_expect(d, 32'(exp_pat[3'(d)]));
    end
  endtask

  task automatic ignored_transfers();
    for (int i = CTRL + 1; i < 16; i++)
    begin
      rng_state = xorshift32(rng_state);
      ahb_write(i, rng_state);
    end
    rng_state = xorshift32(rng_state);
    bus_transfer(1'b0, seg7_pkg::NONSEQ, 1'b1, 0, rng_state);
    rng_state = xorshift32(rng_state);
    bus_transfer(1'b1, seg7_pkg::IDLE, 1'b1, 1, rng_state);
    bus_transfer(1'b1, seg7_pkg::IDLE, 1'b1, CTRL, 32'h1);
    wait_cycles(1);
    for (int d = 0; d < 8; d++)
    begin
      read_expect(d, 32'(exp_pat[3'(d)]));
    end
    for (int i = CTRL; i < 16; i++)
    begin
      read_expect(i, 32'h0);
    end
    check("sh_clk", 32'(sh_clk), 32'h0);
  endtask

  task automatic scan_order();
    logic [15:0] frame;
    int          d;
    ahb_write(CTRL, 32'h1);
    // nine frames, so the wrap back to digit 0 is seen
    for (int i = 0; i < 9; i++)
    begin
      d = i % 8;
      capture_frame(frame);
      check($sformatf("frame of digit %0d", d), 32'(frame),
            32'({exp_pat[3'(d)], 8'(1 << d)}));
    end
    wait_cycles(1);
    read_expect(CTRL, 32'h1);
  endtask

  task automatic disable_and_restart();
    logic [15:0] frame;
    ahb_write(CTRL, 32'h0);
    // write lands, then the serializer clears on the following edge
    wait_cycles(2);
    repeat (QUIET_CYCLES)
    begin
      @(negedge CLK_CM3);
      check("sh_clk", 32'(sh_clk), 32'h0);
      check("ld_clk", 32'(ld_clk), 32'h0);
      check("hc_dat", 32'(hc_dat), 32'h0);
    end
    wait_cycles(1);
    read_expect(CTRL, 32'h0);
    ahb_write(CTRL, 32'h1);
    capture_frame(frame);
    check("frame after restart", 32'(frame), 32'({exp_pat[0], 8'h01}));
    wait_cycles(1);
  endtask

  initial
  begin
    rng_state = 32'd93;
    for (int d = 0; d < 8; d++)
    begin
      exp_pat[3'(d)] = 8'h00;
    end
    reset_dut();
    reset_values();
    digit_readback();
    ignored_transfers();
    scan_order();
    disable_and_restart();
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
logic/seg7_pkg.sv
logic/seg7_reg_if.sv
logic/seg7_bus_slave.sv
logic/seg7_digit_regs.sv
logic/seg7_shift_out.sv
logic/seg7_ahb_top.sv
test/seg7_assertions.sv
test/seg7_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := seg7_tb
FILELIST  := compile.f
BUILD_DIR := obj_dir
LOG       := sim.log
LINTFLAGS := --lint-only --timing --assert
SIMFLAGS  := --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
